//--- logic/cpu_pkg.sv
package cpu_pkg;

	// machine word, also used for addresses
	typedef logic [15:0] word_t;
	typedef logic [2:0]  reg_addr_t;
	// instruction bits 15 to 12
	typedef logic [3:0]  opcode_t;
	typedef logic        alu_op_t;
	// which value a stage writes back
	typedef logic [1:0]  res_sel_t;

	localparam opcode_t OP_ADD = 4'b0000;
	localparam opcode_t OP_ADI = 4'b0001;
	localparam opcode_t OP_NDU = 4'b0010;
	localparam opcode_t OP_LHI = 4'b0011;
	localparam opcode_t OP_LW  = 4'b0100;
	localparam opcode_t OP_SW  = 4'b0101;
	localparam opcode_t OP_NOP = 4'b0111;
	localparam opcode_t OP_BEQ = 4'b1000;
	localparam opcode_t OP_JAL = 4'b1001;

	// bubble word placed in IF/ID on a redirect
	localparam word_t NOP_INSTR = 16'h7000;

	localparam alu_op_t ALU_ADD  = 1'b0;
	localparam alu_op_t ALU_NAND = 1'b1;

	localparam res_sel_t RES_ALU  = 2'd0;
	localparam res_sel_t RES_LHI  = 2'd1;
	localparam res_sel_t RES_LINK = 2'd2;

	typedef struct packed {
		logic     reg_we;
		logic     mem_we;
		logic     mem_to_reg;
		logic     use_imm;
		alu_op_t  alu_op;
		res_sel_t res_sel;
		logic     is_beq;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
		logic  valid;
	} if_id_t;

	typedef struct packed {
		word_t     pc;
		ctrl_t     ctrl;
		word_t     rd1;
		word_t     rd2;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t dest;
		// zero-extended imm6, or the shifted imm9 for LHI
		word_t     imm;
		// sign-extended imm6 for BEQ
		word_t     offset;
		logic      valid;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		reg_addr_t dest;
		word_t     result;
		word_t     store_data;
		logic      valid;
	} ex_mem_t;

	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage
	import cpu_pkg::*;
#(
	parameter word_t RESET_PC = 16'h0000
) (
	input  logic   clk,
	input  logic   rst_n,
	output word_t  imem_addr,
	input  word_t  imem_data,
	input  logic   stall,
	input  logic   jal_redirect,
	input  logic   branch_redirect,
	input  word_t  jal_target,
	input  word_t  branch_target,
	output if_id_t if_id
);

	word_t pc;
	word_t pc_next;

	// instruction memory answers in the same cycle
	assign imem_addr = pc;

	// branch sits in execute, older than the jal in decode, so it wins
	always_comb begin
		if (branch_redirect) begin
			pc_next = branch_target;
		end else if (jal_redirect) begin
			pc_next = jal_target;
		end else if (stall) begin
			pc_next = pc;
		end else begin
			pc_next = pc + 16'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// any redirect discards the word fetched this cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '{pc: RESET_PC, instr: NOP_INSTR, valid: 1'b0};
		end else if (branch_redirect || jal_redirect) begin
			if_id <= '{pc: pc, instr: NOP_INSTR, valid: 1'b0};
		end else if (!stall) begin
			if_id <= '{pc: pc, instr: imem_data, valid: 1'b1};
		end
	end

endmodule

//--- logic/register_file.sv
`timescale 1ns/10ps

module register_file
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  wb_t       wb
);

	// r0 to r7, all general purpose
	word_t regs [8];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// write-through so decode sees a write landing this same cycle
	assign rdata1 = (wb.we && (wb.addr == raddr1)) ? wb.data : regs[raddr1];
	assign rdata2 = (wb.we && (wb.addr == raddr2)) ? wb.data : regs[raddr2];

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  if_id_t    if_id,
	output reg_addr_t raddr1,
	output reg_addr_t raddr2,
	input  word_t     rdata1,
	input  word_t     rdata2,
	input  logic      ex_flush,
	output logic      stall,
	output logic      jal_redirect,
	output word_t     jal_target,
	output id_ex_t    id_ex
);

	opcode_t   opcode;
	ctrl_t     ctrl;
	logic      use_rs1;
	logic      use_rs2;
	reg_addr_t dest;
	word_t     imm;
	word_t     offset;
	logic      load_use;
	id_ex_t    id_ex_d;

	assign opcode = if_id.instr[15:12];

	// control decode, unknown opcodes fall through as nop
	always_comb begin
		ctrl         = '0;
		ctrl.alu_op  = ALU_ADD;
		ctrl.res_sel = RES_ALU;
		use_rs1      = 1'b0;
		use_rs2      = 1'b0;
		// rA is the destination unless the format says otherwise
		dest         = if_id.instr[11:9];
		case (opcode)
			OP_ADD, OP_NDU: begin
				ctrl.reg_we = 1'b1;
				ctrl.alu_op = (opcode == OP_NDU) ? ALU_NAND : ALU_ADD;
				use_rs1     = 1'b1;
				use_rs2     = 1'b1;
				dest        = if_id.instr[5:3];
			end
			OP_ADI: begin
				ctrl.reg_we  = 1'b1;
				ctrl.use_imm = 1'b1;
				use_rs1      = 1'b1;
				dest         = if_id.instr[8:6];
			end
			OP_LHI: begin
				ctrl.reg_we  = 1'b1;
				ctrl.res_sel = RES_LHI;
			end
			OP_LW: begin
				ctrl.reg_we     = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.use_imm    = 1'b1;
				use_rs1         = 1'b1;
			end
			OP_SW: begin
				ctrl.mem_we  = 1'b1;
				ctrl.use_imm = 1'b1;
				use_rs1      = 1'b1;
				use_rs2      = 1'b1;
			end
			OP_BEQ: begin
				ctrl.is_beq = 1'b1;
				use_rs1     = 1'b1;
				use_rs2     = 1'b1;
			end
			OP_JAL: begin
				ctrl.reg_we  = 1'b1;
				ctrl.res_sel = RES_LINK;
			end
			OP_NOP: begin
			end
			default: begin
			end
		endcase
	end

	// loads and stores take rB as the base, a store sends rA as data
	assign raddr1 = (opcode == OP_LW || opcode == OP_SW) ? if_id.instr[8:6] : if_id.instr[11:9];
	assign raddr2 = (opcode == OP_SW) ? if_id.instr[11:9] : if_id.instr[8:6];

	// lhi carries its shifted value down the pipe in the immediate
	assign imm    = (opcode == OP_LHI) ? {if_id.instr[8:0], 7'b0} : {10'b0, if_id.instr[5:0]};
	assign offset = {{10{if_id.instr[5]}}, if_id.instr[5:0]};

	// jal resolves here, one bubble
	assign jal_target   = if_id.pc + {{7{if_id.instr[8]}}, if_id.instr[8:0]};
	assign jal_redirect = if_id.valid && (opcode == OP_JAL) && !ex_flush;

	// load result is not ready until MEM/WB, hold one cycle
	assign load_use = id_ex.valid && id_ex.ctrl.mem_to_reg &&
		((use_rs1 && (raddr1 == id_ex.dest)) || (use_rs2 && (raddr2 == id_ex.dest)));
	assign stall = if_id.valid && load_use;

	always_comb begin
		id_ex_d.pc     = if_id.pc;
		id_ex_d.ctrl   = ctrl;
		id_ex_d.rd1    = rdata1;
		id_ex_d.rd2    = rdata2;
		id_ex_d.rs1    = raddr1;
		id_ex_d.rs2    = raddr2;
		id_ex_d.dest   = dest;
		id_ex_d.imm    = imm;
		id_ex_d.offset = offset;
		// bubble on stall or when a taken beq flushes this slot
		id_ex_d.valid  = if_id.valid && !stall && !ex_flush;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else begin
			id_ex <= id_ex_d;
		end
	end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  id_ex_t  id_ex,
	input  wb_t     wb,
	output logic    branch_redirect,
	output logic    ex_flush,
	output word_t   branch_target,
	output ex_mem_t ex_mem
);

	word_t   op_a;
	word_t   op_b;
	word_t   alu_b;
	word_t   alu_out;
	word_t   result;
	logic    taken;
	ex_mem_t ex_mem_d;

	// newest producer wins, EX/MEM before MEM/WB
	function automatic word_t forward(input reg_addr_t rs, input word_t rd);
		word_t val;
		if (ex_mem.valid && ex_mem.ctrl.reg_we && (ex_mem.dest == rs)) begin
			val = ex_mem.result;
		end else if (wb.we && (wb.addr == rs)) begin
			val = wb.data;
		end else begin
			val = rd;
		end
		return val;
	endfunction

	always_comb begin
		op_a = forward(id_ex.rs1, id_ex.rd1);
		op_b = forward(id_ex.rs2, id_ex.rd2);
	end

	// second operand is the immediate for adi, lw and sw
	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

	always_comb begin
		if (id_ex.ctrl.alu_op == ALU_NAND) begin
			alu_out = ~(op_a & alu_b);
		end else begin
			alu_out = op_a + alu_b;
		end
	end

	// lw and sw leave the address in result
	always_comb begin
		case (id_ex.ctrl.res_sel)
			RES_LHI:  result = id_ex.imm;
			RES_LINK: result = id_ex.pc + 16'd1;
			default:  result = alu_out;
		endcase
	end

	// predicted not taken, so only a taken beq redirects
	assign taken           = id_ex.valid && id_ex.ctrl.is_beq && (op_a == op_b);
	assign branch_redirect = taken;
	assign branch_target   = id_ex.pc + id_ex.offset;
	// kills the instruction now in decode
	assign ex_flush        = taken;

	always_comb begin
		ex_mem_d.ctrl       = id_ex.ctrl;
		ex_mem_d.dest       = id_ex.dest;
		ex_mem_d.result     = result;
		// forwarded rA for sw
		ex_mem_d.store_data = op_b;
		ex_mem_d.valid      = id_ex.valid;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= ex_mem_d;
		end
	end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/10ps

module memory_stage
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t ex_mem,
	output word_t   dmem_addr,
	output word_t   dmem_wdata,
	output logic    dmem_we,
	input  word_t   dmem_rdata,
	output wb_t     wb
);

	word_t wb_data_d;
	logic  wb_we_d;

	// data memory reads combinationally, writes on the edge
	assign dmem_addr  = ex_mem.result;
	assign dmem_wdata = ex_mem.store_data;
	// bubbles never reach memory
	assign dmem_we    = ex_mem.valid && ex_mem.ctrl.mem_we;

	// loads take memory data, everything else the execute result
	assign wb_data_d = ex_mem.ctrl.mem_to_reg ? dmem_rdata : ex_mem.result;
	assign wb_we_d   = ex_mem.valid && ex_mem.ctrl.reg_we;

	// MEM/WB, also the retire port and the forwarding source
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb <= '{we: wb_we_d, addr: ex_mem.dest, data: wb_data_d};
		end
	end

endmodule

//--- logic/pipelined_processor.sv
`timescale 1ns/10ps

module pipelined_processor
	import cpu_pkg::*;
#(
	parameter word_t RESET_PC = 16'h0000
) (
	input  logic      clk,
	input  logic      rst_n,
	output word_t     imem_addr,
	input  word_t     imem_data,
	output word_t     dmem_addr,
	output word_t     dmem_wdata,
	output logic      dmem_we,
	input  word_t     dmem_rdata,
	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data
);

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	wb_t       wb;
	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t     rdata1;
	word_t     rdata2;
	logic      stall;
	logic      jal_redirect;
	logic      branch_redirect;
	logic      ex_flush;
	word_t     jal_target;
	word_t     branch_target;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk, .rst_n, .imem_addr, .imem_data, .stall, .jal_redirect,
		.branch_redirect, .jal_target, .branch_target, .if_id
	);

	decode_stage u_decode (
		.clk, .rst_n, .if_id, .raddr1, .raddr2, .rdata1, .rdata2,
		.ex_flush, .stall, .jal_redirect, .jal_target, .id_ex
	);

	// reads from decode, writes from MEM/WB
	register_file u_regs (.clk, .rst_n, .raddr1, .raddr2, .rdata1, .rdata2, .wb);

	execute_stage u_execute (
		.clk, .rst_n, .id_ex, .wb, .branch_redirect, .ex_flush, .branch_target, .ex_mem
	);

	memory_stage u_memory (
		.clk, .rst_n, .ex_mem, .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata, .wb
	);

	// retired register writes
	assign wb_valid = wb.we;
	assign wb_addr  = wb.addr;
	assign wb_data  = wb.data;

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held for two rising edges, released just after the second
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- dv/pipelined_processor_checker.sv
`timescale 1ns/10ps

module pipelined_processor_checker
	import cpu_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      wb_valid,
	input reg_addr_t wb_addr,
	input word_t     wb_data,
	input logic      dmem_we,
	input word_t     dmem_addr
);

	// pipeline is empty right after reset, nothing retires or stores
	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!wb_valid && !dmem_we))
		else $error("write-back or store active in the first cycle after reset");

	// a retired write carries a known register and value
	wb_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> !$isunknown({wb_addr, wb_data}))
		else $error("write-back port has unknown address or data");

	// store address known whenever the write strobe is up
	store_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_we |-> !$isunknown(dmem_addr))
		else $error("data memory write with unknown address");

endmodule

//--- dv/pipelined_processor_tb.sv
`timescale 1ns/10ps

module pipelined_processor_tb
	import cpu_pkg::*;
;

	// one retired register write or one store
	typedef struct packed {
		logic  is_store;
		word_t addr;
		word_t data;
	} event_t;

	localparam int DRAIN_CYCLES = 12;

	logic      clk;
	logic      rst_n;
	word_t     imem_addr;
	word_t     imem_data;
	word_t     dmem_addr;
	word_t     dmem_wdata;
	logic      dmem_we;
	word_t     dmem_rdata;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;

	word_t  rom[$];
	event_t expected[$];
	word_t  ram [65536];
	int     idx;
	int     checks;
	int     errors;
	int     cycles;
	int     cycle_limit;

	tb_clock u_clock (.clk, .rst_n);

	pipelined_processor #(.RESET_PC(16'h0000)) DUT (
		.clk, .rst_n, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata,
		.dmem_we, .dmem_rdata, .wb_valid, .wb_addr, .wb_data
	);

	bind pipelined_processor pipelined_processor_checker u_checker (
		.clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb_addr(wb_addr),
		.wb_data(wb_data), .dmem_we(dmem_we), .dmem_addr(dmem_addr)
	);

	// ADD and NDU format with rA and rB as sources and rC as destination
	function automatic word_t three_reg_instr(opcode_t op, reg_addr_t ra, reg_addr_t rb,
		reg_addr_t rc);
		return {op, ra, rb, rc, 3'b000};
	endfunction

	// ADI, LW, SW and BEQ format with a 6-bit immediate
	function automatic word_t reg_imm_instr(opcode_t op, reg_addr_t ra, reg_addr_t rb,
		logic [5:0] imm);
		return {op, ra, rb, imm};
	endfunction

	// LHI and JAL format with a 9-bit immediate
	function automatic word_t long_imm_instr(opcode_t op, reg_addr_t ra, logic [8:0] imm);
		return {op, ra, imm};
	endfunction

	function automatic event_t retire_entry(reg_addr_t r, word_t d);
		return '{1'b0, {13'b0, r}, d};
	endfunction

	function automatic event_t store_entry(word_t a, word_t d);
		return '{1'b1, a, d};
	endfunction

	function automatic string event_name(logic is_store);
		return is_store ? "store" : "write-back";
	endfunction

	task automatic write_program();
		// dependent alu chain needing forwarding from both stages
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd1, 6'd5));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd1, 3'd2, 6'd3));
		rom.push_back(three_reg_instr(OP_ADD, 3'd1, 3'd2, 3'd3));
		rom.push_back(three_reg_instr(OP_NDU, 3'd3, 3'd2, 3'd4));
		rom.push_back(long_imm_instr(OP_LHI, 3'd5, 9'h1ab));
		rom.push_back(three_reg_instr(OP_ADD, 3'd5, 3'd4, 3'd6));
		// store, reload, then use at once (load-use stall)
		rom.push_back(reg_imm_instr(OP_SW, 3'd3, 3'd1, 6'd2));
		rom.push_back(reg_imm_instr(OP_LW, 3'd7, 3'd1, 6'd2));
		rom.push_back(three_reg_instr(OP_ADD, 3'd7, 3'd3, 3'd1));
		// r2 written back while the add three slots later reads it
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd2, 6'd9));
		rom.push_back(NOP_INSTR);
		rom.push_back(NOP_INSTR);
		rom.push_back(three_reg_instr(OP_ADD, 3'd2, 3'd2, 3'd3));
		// 9 != 18 so the beq falls through
		rom.push_back(reg_imm_instr(OP_BEQ, 3'd2, 3'd3, 6'd4));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd2, 3'd4, 6'd1));
		// 10 == 10 so it jumps to 20 and kills 17 and 18
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd5, 6'd10));
		rom.push_back(reg_imm_instr(OP_BEQ, 3'd4, 3'd5, 6'd4));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd6, 6'd1));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd7, 6'd2));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd1, 6'd3));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd6, 6'd7));
		// link 22 into r7 and continue at 24
		rom.push_back(long_imm_instr(OP_JAL, 3'd7, 9'd3));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd1, 6'd1));
		rom.push_back(reg_imm_instr(OP_ADI, 3'd0, 3'd1, 6'd2));
		rom.push_back(three_reg_instr(OP_ADD, 3'd7, 3'd6, 3'd2));
		rom.push_back(reg_imm_instr(OP_SW, 3'd2, 3'd0, 6'd16));
	endtask

	task automatic fill_expected();
		expected.push_back(retire_entry(3'd1, 16'h0005));
		expected.push_back(retire_entry(3'd2, 16'h0008));
		expected.push_back(retire_entry(3'd3, 16'h000d));
		// not (13 and 8)
		expected.push_back(retire_entry(3'd4, 16'hfff7));
		expected.push_back(retire_entry(3'd5, 16'hd580));
		// sum wraps at 16 bits
		expected.push_back(retire_entry(3'd6, 16'hd577));
		expected.push_back(store_entry(16'h0007, 16'h000d));
		expected.push_back(retire_entry(3'd7, 16'h000d));
		expected.push_back(retire_entry(3'd1, 16'h001a));
		expected.push_back(retire_entry(3'd2, 16'h0009));
		expected.push_back(retire_entry(3'd3, 16'h0012));
		expected.push_back(retire_entry(3'd4, 16'h000a));
		expected.push_back(retire_entry(3'd5, 16'h000a));
		expected.push_back(retire_entry(3'd6, 16'h0007));
		expected.push_back(retire_entry(3'd7, 16'h0016));
		expected.push_back(retire_entry(3'd2, 16'h001d));
		expected.push_back(store_entry(16'h0010, 16'h001d));
	endtask

	task automatic compare_event(logic is_store, word_t addr, word_t data);
		event_t exp;
		if (idx >= expected.size()) begin
			$display("unexpected %s to %h of %h at %0t after all expected events",
				event_name(is_store), addr, data, $time);
			errors++;
		end else begin
			exp = expected[idx];
			checks++;
			if (exp.is_store != is_store || exp.addr != addr || exp.data != data) begin
				$display("mismatch at %0t: event %0d expected %s %h=%h, got %s %h=%h",
					$time, idx, event_name(exp.is_store), exp.addr, exp.data,
					event_name(is_store), addr, data);
				errors++;
			end
			idx++;
		end
	endtask

	// older write-back before the younger store in the same cycle
	task automatic sample_outputs();
		if (wb_valid) begin
			compare_event(1'b0, {13'b0, wb_addr}, wb_data);
		end
		if (dmem_we) begin
			compare_event(1'b1, dmem_addr, dmem_wdata);
		end
	endtask

	// memories answer through inputs driven 1 ns after the edge
	always @(posedge clk) begin
		#1;
		imem_data = (imem_addr < rom.size()) ? rom[imem_addr] : NOP_INSTR;
		dmem_rdata = ram[dmem_addr];
	end

	// store lands on the edge
	always @(posedge clk) begin
		if (dmem_we) begin
			ram[dmem_addr] <= dmem_wdata;
		end
	end

	initial begin
		imem_data  = NOP_INSTR;
		dmem_rdata = '0;
		idx        = 0;
		checks     = 0;
		errors     = 0;
		cycles     = 0;
		for (int a = 0; a < 65536; a++) begin
			ram[a] = '0;
		end
		write_program();
		fill_expected();
		cycle_limit = 10 * rom.size() + 20;

		@(posedge rst_n);
		// outputs sampled mid-cycle
		while (idx < expected.size() && cycles < cycle_limit) begin
			@(negedge clk);
			cycles++;
			sample_outputs();
		end

		if (idx < expected.size()) begin
			$display("timeout: only %0d of %0d expected events seen after %0d cycles",
				idx, expected.size(), cycles);
			errors++;
		end else begin
			// the rest of the rom is nop, so nothing more may retire
			repeat (DRAIN_CYCLES) begin
				@(negedge clk);
				sample_outputs();
			end
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipelined_processor.sv
dv/tb_clock.sv
dv/pipelined_processor_checker.sv
dv/pipelined_processor_tb.sv
